// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pipelineControlTb -f list.f -Mdir obj_dir -o simv
	./obj_dir/simv 2>&1 | tee sim.log
	@! grep -q "Some tests failed" sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/cpuTypesPkg.sv
package cpuTypesPkg;

    // **************************************************
    // address and instruction words
    // **************************************************

    localparam int addrWidth  = 32;
    localparam int instrWidth = 32;

    localparam logic [addrWidth-1:0] resetPc = 32'h0000_1000;  // first word fetched after reset.

    // **************************************************
    // execute opcodes
    // **************************************************

    typedef enum logic [1:0] {
        opAlu    = 2'd0,
        opMul    = 2'd1,
        opDiv    = 2'd2,
        opMulAcc = 2'd3
    } execOp;

    localparam int latencyWidth = 5;

    // extra cycles the execute stage holds for each opcode, indexed by execOp.
    localparam logic [latencyWidth-1:0] execLatency [4] = '{
        5'd0,   // single cycle ALU op.
        5'd3,
        5'd16,  // the divider is iterative.
        5'd4
    };

endpackage

// File: common/hazardPkg.sv
package hazardPkg;

    typedef enum logic [2:0] {
        stF2 = 3'd0,
        stD  = 3'd1,
        stI  = 3'd2,
        stE  = 3'd3,
        stM  = 3'd4,
        stM2 = 3'd5,
        stM3 = 3'd6,
        stW  = 3'd7
    } stageIdx;

    localparam int numStages = 8;  // width of every stall and flush vector.

    // pending states remember a redirect that met an outstanding fetch.
    typedef enum logic [1:0] {
        hzRun,
        hzExcpPend,
        hzBranchPend,
        hzJumpPend
    } hazState;

    // ordered from highest to lowest priority after causeNone.
    typedef enum logic [2:0] {
        causeNone,
        causeExcp,
        causeDwait,
        causeBranch,
        causeEwait,
        causeJump,
        causeOverflow,
        causeIwait
    } hazCause;

endpackage

// File: hazard/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import hazardPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 branchM,
    input  logic                 jrI,
    input  logic                 overflowI,
    input  logic                 excpM,
    input  logic                 excpW,
    input  logic                 dWait,
    input  logic                 eWait,
    input  logic                 iWait,
    output logic [numStages-1:0] stallVec,
    output logic [numStages-1:0] flushVec,
    output logic                 stallFetch,
    output logic                 redirect
);

    hazState state;
    hazState nextState;
    hazCause cause;

    // mask with one bit set for each stage from first to last.
    function automatic logic [numStages-1:0] stageSpan(stageIdx first, stageIdx last);
        logic [numStages-1:0] mask;
        mask = '0;
        for (int i = 0; i < numStages; i++) begin
            if (i >= int'(first) && i <= int'(last)) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    // **************************************************
    // cause priority
    // **************************************************

    // later assignments override earlier ones, so the list runs from lowest to highest.
    always_comb begin
        cause = causeNone;
        if (iWait)          cause = causeIwait;
        if (overflowI)      cause = causeOverflow;
        if (jrI)            cause = causeJump;
        if (eWait)          cause = causeEwait;
        if (branchM)        cause = causeBranch;
        if (dWait)          cause = causeDwait;
        if (excpM || excpW) cause = causeExcp;
    end

    // **************************************************
    // stall and flush vectors
    // **************************************************

    always_comb begin
        stallVec   = '0;
        flushVec   = '0;
        stallFetch = 1'b0;
        redirect   = 1'b0;
        nextState  = state;

        case (cause)
            causeExcp: begin
                flushVec = excpW ? stageSpan(stF2, stW) : stageSpan(stF2, stM);
                redirect = 1'b1;
            end
            causeDwait: begin
                stallVec   = stageSpan(stF2, stM2);
                flushVec   = stageSpan(stM3, stM3);  // the load result is not ready yet.
                stallFetch = 1'b1;
            end
            causeBranch: begin
                flushVec = stageSpan(stF2, stM);
                redirect = 1'b1;
            end
            causeEwait: begin
                stallVec   = stageSpan(stF2, stE);
                flushVec   = stageSpan(stM, stM);
                stallFetch = 1'b1;
            end
            causeJump: begin
                flushVec = stageSpan(stF2, stI);
                redirect = 1'b1;
            end
            causeOverflow: begin
                stallVec   = stageSpan(stF2, stI);
                stallFetch = 1'b1;
            end
            causeIwait: begin
                flushVec   = stageSpan(stF2, stF2);  // F2 gets a bubble while memory is busy.
                stallFetch = 1'b1;
            end
            default: begin
                stallVec = '0;
            end
        endcase

        if (redirect && iWait) begin
            stallFetch = 1'b1;  // the new address waits for the outstanding word.
            case (cause)
                causeExcp:   nextState = hzExcpPend;
                causeBranch: nextState = hzBranchPend;
                default:     nextState = hzJumpPend;
            endcase
        end else if (state != hzRun && !stallFetch) begin
            // the stale word is delivered in this cycle and must not enter the pipe.
            flushVec[stF2] = 1'b1;
            flushVec[stD]  = 1'b1;
            nextState      = hzRun;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hzRun;
        end else begin
            state <= nextState;
        end
    end

    // a stale word is always discarded before the next fetch request goes out.
    assert property (@(posedge clk) disable iff (reset) $rose(iWait) |-> state == hzRun);

    // no stage register is told to hold and clear in the same cycle.
    assert property (@(posedge clk) disable iff (reset) (stallVec & flushVec) == '0);

endmodule

// File: list.f
common/cpuTypesPkg.sv
common/hazardPkg.sv
hazard/hazardUnit.sv
source/fetchPort.sv
source/multiCycleTimer.sv
source/stageValids.sv
source/pipelineControl.sv
tests/pipelineControlTb.sv

// File: source/fetchPort.sv
`timescale 1ns/1ps

module fetchPort
    import cpuTypesPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stallFetch,
    input  logic                  redirect,
    input  logic [addrWidth-1:0]  redirectAddr,
    input  logic                  fetchAck,
    input  logic [instrWidth-1:0] fetchData,
    output logic                  fetchReq,
    output logic [addrWidth-1:0]  fetchAddr,
    output logic                  iWait,
    output logic                  fetchDone,
    output logic [instrWidth-1:0] instrOut
);

    typedef enum logic [1:0] {
        fsIdle,
        fsReq,
        fsRelease
    } fetchState;

    fetchState             state;
    logic [addrWidth-1:0]  pc;
    logic [addrWidth-1:0]  redirTarget;
    logic                  redirPending;
    logic                  holdValid;
    logic [instrWidth-1:0] holdData;
    logic                  ackSeen;

    assign ackSeen   = (state == fsReq) && fetchAck;
    assign fetchReq  = (state == fsReq);
    assign fetchAddr = pc;
    assign iWait     = (state == fsReq) && !fetchAck;
    assign fetchDone = (ackSeen || holdValid) && !stallFetch;
    assign instrOut  = holdValid ? holdData : fetchData;  // a held word takes precedence.

    // **************************************************
    // four-phase handshake and program counter
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= fsIdle;
            pc           <= resetPc;
            redirPending <= 1'b0;
            holdValid    <= 1'b0;
        end else begin
            case (state)
                fsIdle: begin
                    if (!fetchAck && !stallFetch) begin
                        state <= fsReq;
                    end
                end
                fsReq: begin
                    if (fetchAck) begin
                        state <= fsRelease;  // fetchReq drops in the next cycle.
                    end
                end
                fsRelease: begin
                    if (!fetchAck) begin
                        state <= stallFetch ? fsIdle : fsReq;
                    end
                end
                default: begin
                    state <= fsIdle;
                end
            endcase

            if (ackSeen) begin
                holdValid    <= stallFetch && !redirect;
                redirPending <= 1'b0;
                if (redirect) begin
                    pc <= redirectAddr;
                end else if (redirPending) begin
                    pc <= redirTarget;
                end else begin
                    pc <= pc + addrWidth'(4);
                end
            end else begin
                if (!stallFetch) begin
                    holdValid <= 1'b0;  // the held word leaves with fetchDone.
                end
                if (redirect && state == fsReq) begin
                    redirPending <= 1'b1;
                end else if (redirect) begin
                    pc <= redirectAddr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ackSeen) begin
            holdData <= fetchData;
        end
        if (redirect && iWait) begin
            redirTarget <= redirectAddr;
        end
    end

    // memory samples the address for as long as the request is unanswered.
    assert property (@(posedge clk) disable iff (reset)
        fetchReq && !fetchAck |=> fetchAddr == $past(fetchAddr));

endmodule

// File: source/multiCycleTimer.sv
`timescale 1ns/1ps

module multiCycleTimer
    import cpuTypesPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               execStart,
    input  cpuTypesPkg::execOp execOp,
    output logic               eWait
);

    logic [latencyWidth-1:0] count;  // execute cycles still to wait.

    // **************************************************
    // latency down-counter
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (execStart) begin
            count <= execLatency[execOp];
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high from the cycle after execStart for exactly the loaded number of cycles.
    assign eWait = (count != '0);

    // a new multi-cycle op cannot start while the unit is still busy.
    assert property (@(posedge clk) disable iff (reset) execStart |-> !eWait);

endmodule

// File: source/pipelineControl.sv
`timescale 1ns/1ps

module pipelineControl
    import cpuTypesPkg::*;
    import hazardPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  branchM,
    input  logic                  jrI,
    input  logic                  overflowI,
    input  logic                  excpM,
    input  logic                  excpW,
    input  logic                  dWait,
    input  logic                  execStart,
    input  cpuTypesPkg::execOp    execOp,
    input  logic [addrWidth-1:0]  redirectAddr,
    input  logic                  fetchAck,
    input  logic [instrWidth-1:0] fetchData,
    output logic                  fetchReq,
    output logic [addrWidth-1:0]  fetchAddr,
    output logic [instrWidth-1:0] instrOut,
    output logic                  fetchDone,
    output logic                  eWait,
    output logic [numStages-1:0]  stageValid
);

    logic [numStages-1:0] stallVec;
    logic [numStages-1:0] flushVec;
    logic                 stallFetch;
    logic                 redirect;
    logic                 iWait;

    hazardUnit u_hazard (
        .clk        (clk),
        .reset      (reset),
        .branchM    (branchM),
        .jrI        (jrI),
        .overflowI  (overflowI),
        .excpM      (excpM),
        .excpW      (excpW),
        .dWait      (dWait),
        .eWait      (eWait),
        .iWait      (iWait),
        .stallVec   (stallVec),
        .flushVec   (flushVec),
        .stallFetch (stallFetch),
        .redirect   (redirect)
    );

    fetchPort u_fetch (
        .clk          (clk),
        .reset        (reset),
        .stallFetch   (stallFetch),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .fetchAck     (fetchAck),
        .fetchData    (fetchData),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .iWait        (iWait),
        .fetchDone    (fetchDone),
        .instrOut     (instrOut)
    );

    multiCycleTimer u_timer (
        .clk       (clk),
        .reset     (reset),
        .execStart (execStart),
        .execOp    (execOp),
        .eWait     (eWait)
    );

    stageValids u_valids (
        .clk        (clk),
        .reset      (reset),
        .stallVec   (stallVec),
        .flushVec   (flushVec),
        .fetchDone  (fetchDone),
        .stageValid (stageValid)
    );

endmodule

// File: source/stageValids.sv
`timescale 1ns/1ps

module stageValids
    import hazardPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [numStages-1:0] stallVec,
    input  logic [numStages-1:0] flushVec,
    input  logic                 fetchDone,
    output logic [numStages-1:0] stageValid
);

    logic [numStages-1:0] shiftIn;  // bit leaving the stage in front of each stage.

    // a stalled stage keeps its instruction, so the stage behind it receives a bubble.
    always_comb begin
        shiftIn[stF2] = fetchDone;
        for (int i = 1; i < numStages; i++) begin
            shiftIn[i] = stageValid[i-1] && !stallVec[i-1];
        end
    end

    // **************************************************
    // per-stage update
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= '0;
        end else begin
            for (int i = 0; i < numStages; i++) begin
                if (flushVec[i]) begin
                    stageValid[i] <= 1'b0;
                end else if (stallVec[i]) begin
                    stageValid[i] <= stageValid[i];
                end else begin
                    stageValid[i] <= shiftIn[i];
                end
            end
        end
    end

endmodule

// File: tests/pipelineCases.txt
# wait br jr ov excpM excpW dWait execStart execOp ackDelay idle clearMask(hex)
# wait=1 applies the causes while a fetch is outstanding; ackDelay 0 picks a random delay
0 0 0 0 0 0 0 0 0 0 30 00
0 0 0 0 0 1 0 0 0 2 8 ff
0 0 0 0 1 0 0 0 0 2 8 1f
0 0 0 0 1 0 1 0 0 2 8 1f
0 0 0 0 0 0 1 0 0 2 8 40
0 1 0 0 0 0 0 0 0 2 8 1f
0 0 1 0 0 0 0 0 0 2 8 07
0 0 0 1 0 0 0 0 0 2 8 00
0 0 1 1 0 0 0 0 0 2 8 07
0 0 0 0 0 0 0 1 1 2 0 00
0 1 0 0 0 0 0 0 0 2 6 1f
0 0 0 0 0 0 0 1 0 3 6 00
0 0 0 0 0 0 0 1 1 3 8 00
0 0 0 0 0 0 0 1 2 3 20 00
0 0 0 0 0 0 0 1 3 3 8 00
1 1 0 0 0 0 0 0 0 7 16 1f
1 0 1 0 0 0 0 0 0 7 16 07
1 0 0 0 1 0 0 0 0 7 16 1f
0 0 0 0 0 0 0 0 0 0 30 00

// File: tests/pipelineControlTb.sv
`timescale 1ns/1ps

module pipelineControlTb
    import cpuTypesPkg::*;
();

    logic                  clk;
    logic                  reset;
    logic                  branchM;
    logic                  jrI;
    logic                  overflowI;
    logic                  excpM;
    logic                  excpW;
    logic                  dWait;
    logic                  execStart;
    execOp                 execOpSel;
    logic [addrWidth-1:0]  redirectAddr;
    logic                  fetchAck;
    logic [instrWidth-1:0] fetchData;
    logic                  fetchReq;
    logic [addrWidth-1:0]  fetchAddr;
    logic [instrWidth-1:0] instrOut;
    logic                  fetchDone;
    logic                  eWait;
    logic [7:0]            stageValid;

    int         errorCount = 0;
    integer     seed = 32'h8a78_f34e;
    int         curDelay = 1;        // ack delay of the current case or zero for a random one.
    int         latencyOf [4] = '{0, 3, 16, 4};
    int         modelCount = 0;      // execute wait cycles still expected.
    bit         pend = 1'b0;         // a redirect is waiting for the outstanding word.
    bit         held = 1'b0;         // a fetched word waits out an F2 stall.
    logic [7:0] expValid = '0;
    logic [7:0] clearMask = '0;
    bit         maskArmed = 1'b0;
    bit         prevReq = 1'b0;
    bit         prevAck = 1'b0;
    bit         firstReq = 1'b1;
    bit         expectRedir = 1'b0;
    bit         riseSeen = 1'b0;
    logic [31:0] prevAddr = '0;
    logic [31:0] lastReq = '0;
    logic [31:0] lastAck = '0;
    logic [31:0] nextRedir = 32'h0000_2000;

    pipelineControl u_dut (
        .clk          (clk),
        .reset        (reset),
        .branchM      (branchM),
        .jrI          (jrI),
        .overflowI    (overflowI),
        .excpM        (excpM),
        .excpW        (excpW),
        .dWait        (dWait),
        .execStart    (execStart),
        .execOp       (execOpSel),
        .redirectAddr (redirectAddr),
        .fetchAck     (fetchAck),
        .fetchData    (fetchData),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .instrOut     (instrOut),
        .fetchDone    (fetchDone),
        .eWait        (eWait),
        .stageValid   (stageValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // **************************************************
    // instruction memory with four-phase handshake
    // **************************************************

    always begin : memoryResponder
        int delay;
        int n;
        @(negedge clk);
        if (!reset && fetchReq && !fetchAck) begin
            if (curDelay > 0) begin
                delay = curDelay;
            end else begin
                delay = 1 + ($unsigned($random(seed)) % 4);
            end
            for (n = 1; n < delay; n++) begin
                @(negedge clk);
            end
            @(posedge clk);
            fetchAck  <= 1'b1;
            fetchData <= fetchAddr;  // the word is its own address.
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (fetchReq && n < 50);
            if (fetchReq) begin
                errorCount++;
                $display("memory model: fetchReq stayed high long after fetchAck");
            end
            @(posedge clk);
            fetchAck <= 1'b0;
        end
    end

    // drives the inputs of one clock at the rising edge and checks them at the falling edge.
    task automatic applyCycle(input bit br, input bit jr, input bit ov, input bit em,
                              input bit ew, input bit dw, input bit es, input int op);
        logic [7:0] stallV;
        logic [7:0] flushV;
        logic [7:0] nextValid;
        logic       stallF;
        logic       redir;
        logic       iw;
        logic       ewModel;
        logic       shift;
        logic       ackNow;
        logic       doneExp;
        @(posedge clk);
        branchM      <= br;
        jrI          <= jr;
        overflowI    <= ov;
        excpM        <= em;
        excpW        <= ew;
        dWait        <= dw;
        execStart    <= es;
        execOpSel    <= execOp'(op);
        redirectAddr <= nextRedir;
        @(negedge clk);

        if (prevReq && !prevAck && fetchReq) begin
            checkValue("fetchAddr", prevAddr, fetchAddr);  // held until ack.
        end
        if (fetchReq && !prevReq) begin
            riseSeen = 1'b1;
            if (firstReq) begin
                checkValue("fetchAddr", resetPc, fetchAddr);
            end else if (expectRedir) begin
                checkValue("fetchAddr", nextRedir, fetchAddr);
            end else begin
                checkValue("fetchAddr", lastReq + 4, fetchAddr);
            end
            firstReq    = 1'b0;
            expectRedir = 1'b0;
            lastReq     = fetchAddr;
        end
        ackNow = fetchReq && fetchAck;
        if (ackNow) begin
            lastAck = fetchAddr;
        end
        prevReq  = fetchReq;
        prevAck  = fetchAck;
        prevAddr = fetchAddr;

        checkValue("stageValid", expValid, stageValid);
        if (maskArmed) begin
            checkValue("stageValid flushed", 0, stageValid & clearMask);
            maskArmed = 1'b0;
        end
        ewModel = (modelCount != 0);
        checkValue("eWait", ewModel, eWait);
        iw = fetchReq && !fetchAck;

        // causes rank exception first, then dWait, branch, eWait, jump, overflow and fetch wait.
        stallV = '0;
        flushV = '0;
        stallF = 1'b0;
        redir  = 1'b0;
        if (em || ew) begin
            flushV = ew ? 8'hff : 8'h1f;
            redir  = 1'b1;
        end else if (dw) begin
            stallV = 8'h3f;
            flushV = 8'h40;
            stallF = 1'b1;
        end else if (br) begin
            flushV = 8'h1f;
            redir  = 1'b1;
        end else if (ewModel) begin
            stallV = 8'h0f;
            flushV = 8'h10;
            stallF = 1'b1;
        end else if (jr) begin
            flushV = 8'h07;
            redir  = 1'b1;
        end else if (ov) begin
            stallV = 8'h07;
            stallF = 1'b1;
        end else if (iw) begin
            flushV = 8'h01;
            stallF = 1'b1;
        end
        expectRedir = expectRedir || redir;  // the next request carries redirectAddr.
        if (redir && iw) begin
            pend = 1'b1;
        end else if (pend && !stallF) begin
            flushV[1:0] = 2'b11;  // the stale word must not enter the pipe.
            pend        = 1'b0;
        end

        // a word fetched under an F2 stall is held until the stall clears.
        doneExp = (ackNow || held) && !stallF;
        checkValue("fetchDone", doneExp, fetchDone);
        if (fetchDone) begin
            checkValue("instrOut", lastAck, instrOut);
        end
        if (ackNow) begin
            held = stallF && !redir;
        end else if (!stallF) begin
            held = 1'b0;
        end

        for (int i = 0; i < 8; i++) begin
            shift = (i == 0) ? doneExp : (expValid[i-1] && !stallV[i-1]);
            if (flushV[i]) begin
                nextValid[i] = 1'b0;
            end else if (stallV[i]) begin
                nextValid[i] = expValid[i];
            end else begin
                nextValid[i] = shift;
            end
        end
        expValid = nextValid;

        if (es) begin
            modelCount = latencyOf[op];
        end else if (modelCount != 0) begin
            modelCount--;
        end
    endtask

    task automatic idleCycle();
        applyCycle(0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // **************************************************
    // case reader and main sequence
    // **************************************************

    initial begin : mainSequence
        int    fd;
        int    count;
        int    n;
        int    caseNum;
        string line;
        int    waitFetch, br, jr, ov, em, ew, dw, es, op, delay, idle;
        logic [7:0] mask;
        reset        = 1'b1;
        branchM      = 1'b0;
        jrI          = 1'b0;
        overflowI    = 1'b0;
        excpM        = 1'b0;
        excpW        = 1'b0;
        dWait        = 1'b0;
        execStart    = 1'b0;
        execOpSel    = opAlu;
        redirectAddr = nextRedir;
        fetchAck     = 1'b0;
        fetchData    = '0;
        caseNum      = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("fetchReq", 0, fetchReq);
        checkValue("stageValid", 0, stageValid);

        fd = $fopen("tests/pipelineCases.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the case file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                count = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %h", waitFetch,
                                br, jr, ov, em, ew, dw, es, op, delay, idle, mask);
                if (count != 12) begin
                    errorCount++;
                    $display("malformed case line: %s", line);
                    continue;
                end
                caseNum++;
                curDelay = delay;
                if (br || jr || em || ew) begin
                    nextRedir = 32'h0000_2000 + caseNum * 32;
                end
                if (waitFetch != 0) begin
                    riseSeen = 1'b0;
                    n = 0;
                    while (!(riseSeen && fetchReq && !fetchAck) && n < 100) begin
                        idleCycle();
                        n++;
                    end
                    if (!(riseSeen && fetchReq && !fetchAck)) begin
                        errorCount++;
                        $display("case %0d: no outstanding fetch appeared in time", caseNum);
                    end
                end
                n = 0;
                while (es != 0 && modelCount != 0 && n < 100) begin
                    idleCycle();
                    n++;
                end
                if (es != 0 && modelCount != 0) begin
                    errorCount++;
                    $display("case %0d: execute unit never became free", caseNum);
                end
                applyCycle(br, jr, ov, em, ew, dw, es, op);
                clearMask = mask;
                maskArmed = 1'b1;
                repeat (idle) idleCycle();
            end
            $fclose(fd);
        end
        repeat (4) idleCycle();

        $display("checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("Some tests failed");
        $finish;
    end

endmodule
